// File: design/mem_arbiter.sv
module mem_arbiter (
    input  tsc_pkg::mem_req_t load_req,
    input  tsc_pkg::mem_req_t data_req,
    input  tsc_pkg::mem_req_t fetch_req,
    output tsc_pkg::mem_req_t mem_req,
    output logic              data_gnt,
    output logic              fetch_gnt
);

    // loader, then data stage, then fetch
    always_comb begin
        mem_req   = '0;
        data_gnt  = 1'b0;
        fetch_gnt = 1'b0;
        if (load_req.req) begin
            mem_req = load_req;
        end else if (data_req.req) begin
            mem_req  = data_req;
            data_gnt = 1'b1;
        end else if (fetch_req.req) begin
            mem_req   = fetch_req;
            fetch_gnt = 1'b1;
        end
    end

endmodule

// File: design/tsc_alu.sv
module tsc_alu (
    input  tsc_pkg::alu_op_e           op,
    input  logic [tsc_pkg::word_w-1:0] a,
    input  logic [tsc_pkg::word_w-1:0] b,
    output logic [tsc_pkg::word_w-1:0] result,
    output logic                       equal
);

    always_comb begin
        case (op)
            tsc_pkg::alu_add:    result = a + b;
            tsc_pkg::alu_sub:    result = a - b;
            tsc_pkg::alu_and:    result = a & b;
            tsc_pkg::alu_orr:    result = a | b;
            tsc_pkg::alu_pass_a: result = a;    // WWD carries rs through
            default:             result = '0;
        endcase
    end

    // raw operand compare for BEQ/BNE, b is rt there
    assign equal = (a == b);

endmodule

// File: design/tsc_core.sv
module tsc_core (
    input  logic                       clk,
    input  logic                       rst,
    output tsc_pkg::mem_req_t          fetch_req,
    input  logic                       fetch_gnt,
    output tsc_pkg::mem_req_t          data_req,
    input  logic                       data_gnt,
    input  logic [tsc_pkg::word_w-1:0] rdata,
    output logic [tsc_pkg::word_w-1:0] output_port,
    output logic                       output_valid,
    output logic [tsc_pkg::word_w-1:0] num_inst,
    output logic                       halted
);

    logic [tsc_pkg::word_w-1:0] pc;
    logic                       started;
    logic                       fetch_stop;
    logic                       halt_seen;

    logic                       if_valid;
    tsc_pkg::instr_u            if_instr;
    logic [tsc_pkg::word_w-1:0] if_pc;

    tsc_pkg::ctrl_t             id_ctrl;
    logic [tsc_pkg::word_w-1:0] id_imm;
    logic [tsc_pkg::word_w-1:0] rs_data;
    logic [tsc_pkg::word_w-1:0] rt_data;

    tsc_pkg::id_ex_t  id_ex, id_ex_n;
    tsc_pkg::ex_mem_t ex_mem, ex_mem_n;
    tsc_pkg::mem_wb_t mem_wb, mem_wb_n;

    logic [tsc_pkg::word_w-1:0] alu_b;
    logic [tsc_pkg::word_w-1:0] alu_res;
    logic                       alu_eq;
    logic                       taken;
    logic [tsc_pkg::word_w-1:0] target;
    logic                       fetch_ok;
    logic                       halt_in_id;
    logic                       wb_en;
    logic [tsc_pkg::word_w-1:0] wb_data;

    tsc_decode u_decode (
        .instr (if_instr),
        .ctrl  (id_ctrl),
        .imm   (id_imm)
    );

    tsc_regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .rs_addr (if_instr.r_fields.rs),
        .rt_addr (if_instr.r_fields.rt),
        .rd_addr (mem_wb.dst),
        .w_data  (wb_data),
        .w_en    (wb_en),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    assign alu_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : id_ex.b;

    tsc_alu u_alu (
        .op     (id_ex.ctrl.alu_op),
        .a      (id_ex.a),
        .b      (alu_b),
        .result (alu_res),
        .equal  (alu_eq)
    );

    // branch resolution in EX
    assign taken = id_ex.valid & (id_ex.ctrl.jump
                 | (id_ex.ctrl.branch_eq & alu_eq)
                 | (id_ex.ctrl.branch_ne & ~alu_eq));
    assign target = id_ex.ctrl.jump ? id_ex.imm : id_ex.pc + 16'd1 + id_ex.imm;

    always_comb begin
        fetch_req      = '0;
        fetch_req.req  = started & ~fetch_stop;
        fetch_req.addr = pc;
    end

    assign fetch_ok   = fetch_req.req & fetch_gnt;     // low when MEM owns the memory
    assign halt_in_id = if_valid & id_ctrl.is_halt & ~taken;

    always_comb begin
        data_req       = '0;
        data_req.req   = ex_mem.valid & (ex_mem.ctrl.mem_read | ex_mem.ctrl.mem_write);
        data_req.we    = ex_mem.ctrl.mem_write;
        data_req.addr  = ex_mem.alu_res;
        data_req.wdata = ex_mem.wdata;
    end

    always_comb begin
        id_ex_n.valid = if_valid & ~taken;
        id_ex_n.ctrl  = id_ctrl;
        id_ex_n.pc    = if_pc;
        id_ex_n.a     = rs_data;
        id_ex_n.b     = rt_data;
        id_ex_n.imm   = id_imm;
        id_ex_n.dst   = (if_instr.r_fields.opcode == tsc_pkg::op_rtype)
                      ? if_instr.r_fields.rd : if_instr.i_fields.rt;

        ex_mem_n.valid   = id_ex.valid;
        ex_mem_n.ctrl    = id_ex.ctrl;
        ex_mem_n.alu_res = alu_res;
        ex_mem_n.wdata   = id_ex.b;     // SWD stores rt
        ex_mem_n.dst     = id_ex.dst;

        mem_wb_n.valid    = ex_mem.valid;
        mem_wb_n.ctrl     = ex_mem.ctrl;
        mem_wb_n.alu_res  = ex_mem.alu_res;
        mem_wb_n.mem_data = data_gnt ? rdata : '0;
        mem_wb_n.dst      = ex_mem.dst;
    end

    always_ff @(posedge clk) begin
        if_instr <= rdata;
        if_pc    <= pc;
        id_ex    <= id_ex_n;
        ex_mem   <= ex_mem_n;
        mem_wb   <= mem_wb_n;
        if (rst) begin
            if_valid     <= 1'b0;
            id_ex.valid  <= 1'b0;
            ex_mem.valid <= 1'b0;
            mem_wb.valid <= 1'b0;
        end else begin
            if_valid <= fetch_ok & ~taken & ~halt_in_id;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= '0;
            started    <= 1'b0;
            fetch_stop <= 1'b0;
            halt_seen  <= 1'b0;
            num_inst   <= '0;
        end else begin
            started <= 1'b1;
            if (taken)
                pc <= target;
            else if (fetch_ok && !halt_in_id)
                pc <= pc + 16'd1;
            if (halt_in_id)
                fetch_stop <= 1'b1;     // no more fetches until rst
            if (mem_wb.valid)
                num_inst <= num_inst + 16'd1;
            if (mem_wb.valid && mem_wb.ctrl.is_halt)
                halt_seen <= 1'b1;
        end
    end

    assign wb_en   = mem_wb.valid & mem_wb.ctrl.reg_write;
    assign wb_data = mem_wb.ctrl.mem_to_reg ? mem_wb.mem_data : mem_wb.alu_res;

    assign output_port  = mem_wb.alu_res;
    assign output_valid = mem_wb.valid & mem_wb.ctrl.is_wwd;
    assign halted       = halt_seen | (mem_wb.valid & mem_wb.ctrl.is_halt);

endmodule

// File: design/tsc_decode.sv
module tsc_decode (
    input  tsc_pkg::instr_u            instr,
    output tsc_pkg::ctrl_t             ctrl,
    output logic [tsc_pkg::word_w-1:0] imm
);

    logic [3:0] opcode;
    logic [5:0] func;

    assign opcode = instr.r_fields.opcode;
    assign func   = instr.r_fields.func;

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = tsc_pkg::alu_add;
        case (opcode)
            tsc_pkg::op_rtype: begin
                case (func)
                    tsc_pkg::fn_add: ctrl.reg_write = 1'b1;
                    tsc_pkg::fn_sub: begin
                        ctrl.alu_op    = tsc_pkg::alu_sub;
                        ctrl.reg_write = 1'b1;
                    end
                    tsc_pkg::fn_and: begin
                        ctrl.alu_op    = tsc_pkg::alu_and;
                        ctrl.reg_write = 1'b1;
                    end
                    tsc_pkg::fn_orr: begin
                        ctrl.alu_op    = tsc_pkg::alu_orr;
                        ctrl.reg_write = 1'b1;
                    end
                    tsc_pkg::fn_wwd: begin
                        ctrl.alu_op = tsc_pkg::alu_pass_a;
                        ctrl.is_wwd = 1'b1;
                    end
                    tsc_pkg::fn_hlt: ctrl.is_halt = 1'b1;
                    default: ;      // unknown func retires as a nop
                endcase
            end
            tsc_pkg::op_adi: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
            end
            tsc_pkg::op_lwd: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
                ctrl.reg_write   = 1'b1;
            end
            tsc_pkg::op_swd: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
            end
            tsc_pkg::op_beq: ctrl.branch_eq = 1'b1;
            tsc_pkg::op_bne: ctrl.branch_ne = 1'b1;
            tsc_pkg::op_jmp: ctrl.jump = 1'b1;
            default: ;
        endcase
    end

    // 12-bit jump target is everything below the opcode
    assign imm = (opcode == tsc_pkg::op_jmp)
               ? {4'b0, instr.i_fields.rs, instr.i_fields.rt, instr.i_fields.imm}
               : {{8{instr.i_fields.imm[7]}}, instr.i_fields.imm};

endmodule

// File: design/tsc_pkg.sv
package tsc_pkg;

    localparam int word_w    = 16;
    localparam int mem_depth = 256;
    localparam int mem_aw    = 8;   // low address bits that reach the array
    localparam int reg_count = 4;
    localparam int reg_aw    = 2;

    localparam logic [3:0] op_rtype = 4'd15;
    localparam logic [3:0] op_adi   = 4'd4;
    localparam logic [3:0] op_lwd   = 4'd7;
    localparam logic [3:0] op_swd   = 4'd8;
    localparam logic [3:0] op_bne   = 4'd0;
    localparam logic [3:0] op_beq   = 4'd1;
    localparam logic [3:0] op_jmp   = 4'd9;

    localparam logic [5:0] fn_add = 6'd0;
    localparam logic [5:0] fn_sub = 6'd1;
    localparam logic [5:0] fn_and = 6'd2;
    localparam logic [5:0] fn_orr = 6'd3;
    localparam logic [5:0] fn_wwd = 6'd28;
    localparam logic [5:0] fn_hlt = 6'd29;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_orr,
        alu_pass_a
    } alu_op_e;

    typedef struct packed {
        logic [3:0]        opcode;
        logic [reg_aw-1:0] rs;
        logic [reg_aw-1:0] rt;
        logic [reg_aw-1:0] rd;
        logic [5:0]        func;
    } r_fields_t;

    typedef struct packed {
        logic [3:0]        opcode;
        logic [reg_aw-1:0] rs;
        logic [reg_aw-1:0] rt;
        logic [7:0]        imm;
    } i_fields_t;

    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
    } instr_u;

    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src_imm;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    branch_eq;
        logic    branch_ne;
        logic    jump;
        logic    is_wwd;
        logic    is_halt;
    } ctrl_t;

    typedef struct packed {
        logic              req;
        logic              we;
        logic [word_w-1:0] addr;
        logic [word_w-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic              valid;
        ctrl_t             ctrl;
        logic [word_w-1:0] pc;
        logic [word_w-1:0] a;     // rs value
        logic [word_w-1:0] b;     // rt value
        logic [word_w-1:0] imm;
        logic [reg_aw-1:0] dst;
    } id_ex_t;

    typedef struct packed {
        logic              valid;
        ctrl_t             ctrl;
        logic [word_w-1:0] alu_res;
        logic [word_w-1:0] wdata;
        logic [reg_aw-1:0] dst;
    } ex_mem_t;

    typedef struct packed {
        logic              valid;
        ctrl_t             ctrl;
        logic [word_w-1:0] alu_res;
        logic [word_w-1:0] mem_data;
        logic [reg_aw-1:0] dst;
    } mem_wb_t;

endpackage

// File: design/tsc_regfile.sv
module tsc_regfile (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [tsc_pkg::reg_aw-1:0] rs_addr,
    input  logic [tsc_pkg::reg_aw-1:0] rt_addr,
    input  logic [tsc_pkg::reg_aw-1:0] rd_addr,
    input  logic [tsc_pkg::word_w-1:0] w_data,
    input  logic                       w_en,
    output logic [tsc_pkg::word_w-1:0] rs_data,
    output logic [tsc_pkg::word_w-1:0] rt_data
);

    logic [tsc_pkg::word_w-1:0] regs [tsc_pkg::reg_count];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < tsc_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (w_en) begin
            regs[rd_addr] <= w_data;
        end
    end

    // write-through so WB and ID can share a cycle
    always_comb begin
        rs_data = regs[rs_addr];
        rt_data = regs[rt_addr];
        if (w_en && rd_addr == rs_addr)
            rs_data = w_data;
        if (w_en && rd_addr == rt_addr)
            rt_data = w_data;
    end

endmodule

// File: design/tsc_system.sv
module tsc_system (
    input  logic                       clk,
    input  logic                       rst,
    input  tsc_pkg::mem_req_t          load_req,
    output logic [tsc_pkg::word_w-1:0] load_rdata,
    output logic [tsc_pkg::word_w-1:0] output_port,
    output logic                       output_valid,
    output logic [tsc_pkg::word_w-1:0] num_inst,
    output logic                       halted
);

    tsc_pkg::mem_req_t          fetch_req;
    tsc_pkg::mem_req_t          data_req;
    tsc_pkg::mem_req_t          mem_req;
    logic                       fetch_gnt;
    logic                       data_gnt;
    logic [tsc_pkg::word_w-1:0] rdata;

    assign load_rdata = rdata;

    tsc_core u_core (
        .clk          (clk),
        .rst          (rst),
        .fetch_req    (fetch_req),
        .fetch_gnt    (fetch_gnt),
        .data_req     (data_req),
        .data_gnt     (data_gnt),
        .rdata        (rdata),
        .output_port  (output_port),
        .output_valid (output_valid),
        .num_inst     (num_inst),
        .halted       (halted)
    );

    mem_arbiter u_arbiter (
        .load_req  (load_req),
        .data_req  (data_req),
        .fetch_req (fetch_req),
        .mem_req   (mem_req),
        .data_gnt  (data_gnt),
        .fetch_gnt (fetch_gnt)
    );

    unified_mem u_mem (
        .clk     (clk),
        .mem_req (mem_req),
        .rdata   (rdata)
    );

endmodule

// File: design/unified_mem.sv
module unified_mem (
    input  logic                       clk,
    input  tsc_pkg::mem_req_t          mem_req,
    output logic [tsc_pkg::word_w-1:0] rdata
);

    logic [tsc_pkg::word_w-1:0] mem [tsc_pkg::mem_depth];
    logic [tsc_pkg::mem_aw-1:0] addr;

    assign addr  = mem_req.addr[tsc_pkg::mem_aw-1:0];   // upper bits ignored
    assign rdata = mem[addr];

    always_ff @(posedge clk) begin
        if (mem_req.req && mem_req.we)
            mem[addr] <= mem_req.wdata;
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -f verilog.f --top-module tsc_system_tb -o tsc_sim \
    && ./obj_dir/tsc_sim 2>&1 | tee sim.log \
    || { echo "build or simulation failed"; exit 1; }
grep -q "Test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: tb/program_stimulus.txt
# P <addr> <word> loads one program word, E <value> is the next expected WWD output
# N <count> is num_inst after HLT, all values in hex, text after a hash is ignored
P 00 4105  # ADI r1, r0, 5
P 01 42FD  # ADI r2, r0, -3
P 02 430E  # ADI r3, r0, 14
P 03 F41C  # WWD r1
P 04 F81C  # WWD r2
P 05 F700  # ADD r0, r1, r3
P 06 FD41  # SUB r1, r3, r1
P 07 FB82  # AND r2, r2, r3
P 08 F01C  # WWD r0
P 09 F41C  # WWD r1
P 0A F81C  # WWD r2
P 0B FDC3  # ORR r3, r3, r1
P 0C 8834  # SWD r0 to r2 + 0x34
P 0D 7934  # LWD r1 from r2 + 0x34
P 0E FC1C  # WWD r3
P 0F 4A21  # ADI r2, r2, 0x21
P 10 F41C  # WWD r1
P 11 0101  # BNE r0, r1 not taken
P 12 F81C  # WWD r2
P 13 1101  # BEQ r0, r1 taken to 0x15
P 14 FC1C  # WWD r3 skipped
P 15 9017  # JMP 0x17
P 16 F81C  # WWD r2 skipped
P 17 F01D  # HLT
E 0005
E FFFD
E 0013
E 0009
E 000C
E 000F
E 0013
E 002D
N 0016

// File: tb/tsc_system_tb.sv
module tsc_system_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                       clk = 1'b0;
    logic                       rst;
    tsc_pkg::mem_req_t          load_req;
    logic [tsc_pkg::word_w-1:0] load_rdata;
    logic [tsc_pkg::word_w-1:0] output_port;
    logic                       output_valid;
    logic [tsc_pkg::word_w-1:0] num_inst;
    logic                       halted;

    logic [tsc_pkg::word_w-1:0] prog_addr [$];
    logic [tsc_pkg::word_w-1:0] prog_word [$];
    logic [tsc_pkg::word_w-1:0] exp_out [$];
    logic [tsc_pkg::word_w-1:0] exp_count;
    int                         out_seen = 0;
    bit                         stim_ready = 1'b0;

    tsc_system DUT (
        .clk          (clk),
        .rst          (rst),
        .load_req     (load_req),
        .load_rdata   (load_rdata),
        .output_port  (output_port),
        .output_valid (output_valid),
        .num_inst     (num_inst),
        .halted       (halted)
    );

    always #5 clk = ~clk;

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_output(input logic [tsc_pkg::word_w-1:0] got,
                                input logic [tsc_pkg::word_w-1:0] exp);
        if (got !== exp)
            stop_with_error($sformatf("Fail: output_port is %h, expected %h", got, exp));
    endtask

    task automatic check_count(input logic [tsc_pkg::word_w-1:0] got,
                               input logic [tsc_pkg::word_w-1:0] exp);
        if (got !== exp)
            stop_with_error($sformatf("Fail: num_inst is %h, expected %h", got, exp));
    endtask

    task automatic check_load_rdata(input logic [tsc_pkg::word_w-1:0] got,
                                    input logic [tsc_pkg::word_w-1:0] exp);
        if (got !== exp)
            stop_with_error($sformatf("Fail: load_rdata is %h, expected %h", got, exp));
    endtask

    task automatic read_stimulus();
        int                         fd;
        int                         n;
        logic [7:0]                 tag;
        logic [tsc_pkg::word_w-1:0] v1;
        logic [tsc_pkg::word_w-1:0] v2;
        fd = $fopen("tb/program_stimulus.txt", "r");
        if (fd == 0)
            stop_with_error("could not open tb/program_stimulus.txt");
        n = $fscanf(fd, " %c", tag);
        while (n == 1) begin
            case (tag)
                "#": begin
                    while (n == 1 && tag != 8'h0a)   // rest of the line is a comment
                        n = $fscanf(fd, "%c", tag);
                end
                "P": begin
                    n = $fscanf(fd, "%h %h", v1, v2);
                    prog_addr.push_back(v1);
                    prog_word.push_back(v2);
                end
                "E": begin
                    n = $fscanf(fd, "%h", v1);
                    exp_out.push_back(v1);
                end
                "N": begin
                    n = $fscanf(fd, "%h", v1);
                    exp_count = v1;
                end
                default: stop_with_error("unknown line tag in the stimulus file");
            endcase
            n = $fscanf(fd, " %c", tag);
        end
        $fclose(fd);
    endtask

    // reset lasts 8 cycles or until every word is written and read back
    task automatic load_program();
        int cycles;
        cycles = 0;
        for (int i = 0; i < prog_word.size(); i++) begin
            @(posedge clk);
            #1;
            load_req.req   = 1'b1;
            load_req.we    = 1'b1;
            load_req.addr  = prog_addr[i];
            load_req.wdata = prog_word[i];
            cycles++;
        end
        // read each word back through the loader port
        for (int i = 0; i < prog_word.size(); i++) begin
            @(posedge clk);
            #1;
            load_req.req   = 1'b1;
            load_req.we    = 1'b0;
            load_req.addr  = prog_addr[i];
            load_req.wdata = '0;
            cycles++;
            @(negedge clk);
            check_load_rdata(load_rdata, prog_word[i]);
        end
        @(posedge clk);
        #1;
        load_req = '0;
        cycles++;
        while (cycles < 8) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        rst = 1'b0;
    endtask

    // every WWD result is compared in order
    always @(negedge clk) begin
        if (!rst && output_valid) begin
            if (out_seen >= exp_out.size()) begin
                stop_with_error("output_valid pulsed with no expected value left");
            end else begin
                check_output(output_port, exp_out[out_seen]);
                out_seen++;
            end
        end
    end

    initial begin
        wait (stim_ready);
        repeat (prog_word.size() * 20 + 200) @(posedge clk);
        stop_with_error("timeout, the core did not halt in time");
    end

    initial begin
        rst      = 1'b1;
        load_req = '0;
        read_stimulus();
        stim_ready = 1'b1;
        load_program();
        while (!halted)
            @(negedge clk);
        if (out_seen != exp_out.size()) begin
            stop_with_error("halted before all expected output values were seen");
        end else begin
            repeat (20) begin
                @(negedge clk);
                if (!halted)
                    stop_with_error("halted dropped after the program ended");
            end
            check_count(num_inst, exp_count);
            $display("Test passed");
            $finish;
        end
    end

endmodule

// File: verilog.f
design/tsc_pkg.sv
design/tsc_regfile.sv
design/tsc_alu.sv
design/tsc_decode.sv
design/tsc_core.sv
design/mem_arbiter.sv
design/unified_mem.sv
design/tsc_system.sv
tb/tsc_system_tb.sv
